/* design/exp_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module exp_sequencer #(
	parameter int WORDS = 2
) (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic [WORDS*rsa_arith_pkg::WORD_W-1:0] exp_val,
	input logic [WORDS*rsa_arith_pkg::WORD_W-1:0] message,
	output rsa_arith_pkg::mul_req_t req,
	input rsa_arith_pkg::mul_rsp_t rsp,
	output logic busy,
	output rsa_arith_pkg::word_t result,
	output logic result_valid,
	output logic done
);

	localparam int WW = rsa_arith_pkg::WORD_W;
	localparam int OP_W = WORDS * WW;
	localparam int BIT_W = $clog2(OP_W);
	localparam int OUT_W = (WORDS > 1) ? $clog2(WORDS) : 1;

	rsa_host_pkg::seq_state_e state;
	logic [BIT_W-1:0] bit_idx;
	logic [OUT_W-1:0] out_idx;
	logic squared;
	logic [OP_W-1:0] acc;

	// left-to-right scan, one product in flight at a time
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= rsa_host_pkg::SEQ_IDLE;
			bit_idx <= '0;
			out_idx <= '0;
			squared <= 1'b0;
		end else begin
			case (state)
				rsa_host_pkg::SEQ_IDLE: begin
					if (start) begin
						bit_idx <= BIT_W'(OP_W - 1);
						state <= rsa_host_pkg::SEQ_SQUARE;
					end
				end
				rsa_host_pkg::SEQ_SQUARE: begin
					squared <= 1'b1;
					state <= rsa_host_pkg::SEQ_WAIT;
				end
				rsa_host_pkg::SEQ_MULT: begin
					squared <= 1'b0;
					state <= rsa_host_pkg::SEQ_WAIT;
				end
				rsa_host_pkg::SEQ_WAIT: begin
					if (rsp.valid) begin
						if (squared && exp_val[bit_idx]) begin
							state <= rsa_host_pkg::SEQ_MULT;
						end else if (bit_idx == '0) begin
							out_idx <= OUT_W'(WORDS - 1);
							state <= rsa_host_pkg::SEQ_OUTPUT;
						end else begin
							bit_idx <= bit_idx - 1'b1;
							state <= rsa_host_pkg::SEQ_SQUARE;
						end
					end
				end
				rsa_host_pkg::SEQ_OUTPUT: begin
					// most significant word first
					if (out_idx == '0)
						state <= rsa_host_pkg::SEQ_IDLE;
					else
						out_idx <= out_idx - 1'b1;
				end
				default: begin
					state <= rsa_host_pkg::SEQ_IDLE;
				end
			endcase
		end
	end

	// accumulator starts at 1, so leading zero bits just square 1
	always_ff @(posedge clk) begin
		if (state == rsa_host_pkg::SEQ_IDLE && start)
			acc <= OP_W'(1);
		else if (state == rsa_host_pkg::SEQ_WAIT && rsp.valid)
			acc <= rsp.product[OP_W-1:0];
	end

	assign busy = (state != rsa_host_pkg::SEQ_IDLE);

	assign req.valid = (state == rsa_host_pkg::SEQ_SQUARE) ||
		(state == rsa_host_pkg::SEQ_MULT);
	assign req.multiplicand = rsa_arith_pkg::operand_t'(acc);
	assign req.multiplier = (state == rsa_host_pkg::SEQ_MULT) ?
		rsa_arith_pkg::operand_t'(message) : rsa_arith_pkg::operand_t'(acc);

	assign result = acc[out_idx * WW +: WW];
	assign result_valid = (state == rsa_host_pkg::SEQ_OUTPUT);
	assign done = result_valid && (out_idx == '0);

endmodule

`default_nettype wire

/* design/key_store.sv */
`timescale 1ns/10ps
`default_nettype none

module key_store #(
	parameter int WORDS = 2
) (
	input logic clk,
	input logic rst_n,
	input logic wr_valid,
	input rsa_host_pkg::host_wr_t wr,
	input logic busy,
	output logic [WORDS*rsa_arith_pkg::WORD_W-1:0] exp_val,
	output logic [WORDS*rsa_arith_pkg::WORD_W-1:0] modulus,
	output logic [WORDS*rsa_arith_pkg::WORD_W-1:0] message
);

	logic accept;
	int unsigned lsb;

	// operands must stay stable while the engine runs
	assign accept = wr_valid && !busy && (int'(wr.index) < WORDS);
	assign lsb = wr.index * rsa_arith_pkg::WORD_W;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exp_val <= '0;
			modulus <= '0;
			message <= '0;
		end else if (accept) begin
			case (wr.target)
				rsa_host_pkg::TGT_EXP: begin
					exp_val[lsb +: rsa_arith_pkg::WORD_W] <= wr.data;
				end
				rsa_host_pkg::TGT_MOD: begin
					modulus[lsb +: rsa_arith_pkg::WORD_W] <= wr.data;
				end
				rsa_host_pkg::TGT_MSG: begin
					message[lsb +: rsa_arith_pkg::WORD_W] <= wr.data;
				end
				default: begin
					// unused target code, nothing stored
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/lane_reducer.sv */
`timescale 1ns/10ps
`default_nettype none

module lane_reducer #(
	parameter int WORDS = 2
) (
	input logic clk,
	input logic rst_n,
	input rsa_arith_pkg::lane_t parts [WORDS],
	input logic parts_valid,
	input logic [WORDS*rsa_arith_pkg::WORD_W-1:0] modulus,
	output rsa_arith_pkg::mul_rsp_t rsp
);

	localparam int OP_W = WORDS * rsa_arith_pkg::WORD_W;
	// one spare word holds the carries of the lane sum
	localparam int SUM_W = (2 * WORDS + 1) * rsa_arith_pkg::WORD_W;

	logic [SUM_W-1:0] sum;
	logic [SUM_W-1:0] rem;
	logic rsp_valid;
	logic [OP_W-1:0] product;

	always_comb begin
		sum = '0;
		for (int k = 0; k < WORDS; k++) begin
			sum = sum + parts[k][SUM_W-1:0];
		end
	end

	assign rem = sum % {{(SUM_W-OP_W){1'b0}}, modulus};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= parts_valid;
	end

	always_ff @(posedge clk) begin
		product <= rem[OP_W-1:0];
	end

	assign rsp.valid = rsp_valid;
	assign rsp.product = rsa_arith_pkg::operand_t'(product);

endmodule

`default_nettype wire

/* design/rsa_arith_pkg.sv */
`default_nettype none

package rsa_arith_pkg;

	localparam int WORD_W = 32;

	// widest supported operand, in words
	localparam int MAX_WORDS = 64;

	typedef logic [WORD_W-1:0] word_t;

	// modules use only the low WORDS words
	typedef logic [MAX_WORDS*WORD_W-1:0] operand_t;

	// partial product after its word shift
	typedef logic [(2*MAX_WORDS+1)*WORD_W-1:0] lane_t;

	typedef struct packed {
		logic valid;
		operand_t multiplicand;
		operand_t multiplier;
	} mul_req_t;

	typedef struct packed {
		logic valid;
		operand_t product;
	} mul_rsp_t;

endpackage

`default_nettype wire

/* design/rsa_core.sv */
`timescale 1ns/10ps
`default_nettype none

module rsa_core #(
	parameter int WORDS = 2
) (
	input logic clk,
	input logic rst_n,
	input logic wr_valid,
	input rsa_host_pkg::host_wr_t wr,
	input logic start,
	output rsa_arith_pkg::word_t result,
	output logic result_valid,
	output logic done,
	output logic busy
);

	localparam int OP_W = WORDS * rsa_arith_pkg::WORD_W;

	logic [OP_W-1:0] exp_val;
	logic [OP_W-1:0] modulus;
	logic [OP_W-1:0] message;
	rsa_arith_pkg::mul_req_t req;
	rsa_arith_pkg::mul_rsp_t rsp;
	rsa_arith_pkg::lane_t parts [WORDS];
	logic [WORDS-1:0] part_valid;

	key_store #(.WORDS(WORDS)) key_store_i (
		.clk(clk),
		.rst_n(rst_n),
		.wr_valid(wr_valid),
		.wr(wr),
		.busy(busy),
		.exp_val(exp_val),
		.modulus(modulus),
		.message(message)
	);

	exp_sequencer #(.WORDS(WORDS)) exp_sequencer_i (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.exp_val(exp_val),
		.message(message),
		.req(req),
		.rsp(rsp),
		.busy(busy),
		.result(result),
		.result_valid(result_valid),
		.done(done)
	);

	// one lane per multiplier word
	for (genvar k = 0; k < WORDS; k++) begin : g_lane
		word_lane #(.WORDS(WORDS), .LANE(k)) word_lane_i (
			.clk(clk),
			.rst_n(rst_n),
			.req(req),
			.part(parts[k]),
			.part_valid(part_valid[k])
		);
	end

	// lanes move in lockstep, lane 0 speaks for all
	lane_reducer #(.WORDS(WORDS)) lane_reducer_i (
		.clk(clk),
		.rst_n(rst_n),
		.parts(parts),
		.parts_valid(part_valid[0]),
		.modulus(modulus),
		.rsp(rsp)
	);

endmodule

`default_nettype wire

/* design/rsa_host_pkg.sv */
`default_nettype none

package rsa_host_pkg;

	typedef enum logic [1:0] {
		TGT_EXP,
		TGT_MOD,
		TGT_MSG
	} target_e;

	// index 0 is the least significant word
	typedef struct packed {
		target_e target;
		logic [5:0] index;
		rsa_arith_pkg::word_t data;
	} host_wr_t;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_SQUARE,
		SEQ_MULT,
		SEQ_WAIT,
		SEQ_OUTPUT
	} seq_state_e;

endpackage

`default_nettype wire

/* design/word_lane.sv */
`timescale 1ns/10ps
`default_nettype none

module word_lane #(
	parameter int WORDS = 2,
	parameter int LANE = 0
) (
	input logic clk,
	input logic rst_n,
	input rsa_arith_pkg::mul_req_t req,
	output rsa_arith_pkg::lane_t part,
	output logic part_valid
);

	localparam int WW = rsa_arith_pkg::WORD_W;
	localparam int OP_W = WORDS * WW;

	logic [OP_W-1:0] mcand;
	logic [WW-1:0] mword;
	logic [OP_W+WW-1:0] prod;

	assign mcand = req.multiplicand[OP_W-1:0];
	assign mword = req.multiplier[LANE*WW +: WW];
	assign prod = {{WW{1'b0}}, mcand} * {{OP_W{1'b0}}, mword};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			part_valid <= 1'b0;
		else
			part_valid <= req.valid;
	end

	// weight of multiplier word LANE
	always_ff @(posedge clk) begin
		part <= rsa_arith_pkg::lane_t'(prod) << (LANE * WW);
	end

endmodule

`default_nettype wire

/* files.f */
design/rsa_arith_pkg.sv
design/rsa_host_pkg.sv
design/key_store.sv
design/word_lane.sv
design/lane_reducer.sv
design/exp_sequencer.sv
design/rsa_core.sv
tb/rsa_core_checker.sv
tb/rsa_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module rsa_core_tb -f files.f
./obj_dir/Vrsa_core_tb | tee sim.log
if grep -q "Done: no errors" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* tb/rsa_core_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module rsa_core_checker (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic busy,
	input logic result_valid,
	input logic done,
	input logic req_valid,
	input logic rsp_valid,
	input rsa_host_pkg::seq_state_e state
);

	assert property (@(posedge clk) disable iff (!rst_n) done |-> result_valid)
		else $error("done without result_valid");

	assert property (@(posedge clk) disable iff (!rst_n) result_valid |-> busy)
		else $error("result_valid while idle");

	// only a wait step may lead back to square, a restart would jump there
	assert property (@(posedge clk) disable iff (!rst_n)
		(start && busy && state != rsa_host_pkg::SEQ_WAIT)
		|=> state != rsa_host_pkg::SEQ_SQUARE)
		else $error("start while busy changed the sequencer state");

	// lane stage then reducer stage
	assert property (@(posedge clk) disable iff (!rst_n) req_valid |-> ##2 rsp_valid)
		else $error("multiply response missing two cycles after request");

endmodule

bind rsa_core rsa_core_checker checker_i (
	.clk(clk),
	.rst_n(rst_n),
	.start(start),
	.busy(busy),
	.result_valid(result_valid),
	.done(done),
	.req_valid(req.valid),
	.rsp_valid(rsp.valid),
	.state(exp_sequencer_i.state)
);

`default_nettype wire

/* tb/rsa_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module rsa_core_tb;

	localparam int WORDS = 2;
	localparam int WW = rsa_arith_pkg::WORD_W;
	localparam int OP_W = WORDS * WW;
	localparam int NUM_ROWS = 5;
	localparam int CYCLE_LIMIT = NUM_ROWS * (4 * 64 * WORDS + 100) + 16;

	typedef struct packed {
		logic [OP_W-1:0] exp_val;
		logic [OP_W-1:0] modulus;
		logic [OP_W-1:0] message;
		logic reload;
		logic [OP_W-1:0] expected;
	} row_t;

	logic clk;
	logic rst_n;
	logic wr_valid;
	rsa_host_pkg::host_wr_t wr;
	logic start;
	rsa_arith_pkg::word_t result;
	logic result_valid;
	logic done;
	logic busy;
	row_t rows [NUM_ROWS];
	int errors;
	int cycles;
	integer seed;

	rsa_core #(.WORDS(WORDS)) dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.wr_valid(wr_valid),
		.wr(wr),
		.start(start),
		.result(result),
		.result_valid(result_valid),
		.done(done),
		.busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the DUT never finished its runs", cycles);
		$display("Done: errors found");
		$finish;
	end

	// left-to-right square-and-multiply on double-width vectors
	function automatic logic [OP_W-1:0] mod_pow(input logic [OP_W-1:0] base,
		input logic [OP_W-1:0] e, input logic [OP_W-1:0] n);
		logic [2*OP_W-1:0] acc;
		acc = 1;
		for (int i = OP_W - 1; i >= 0; i--) begin
			acc = (acc * acc) % n;
			if (e[i])
				acc = (acc * base) % n;
		end
		return acc[OP_W-1:0];
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic report(input string msg);
		errors++;
		$display("error at %0t: %s", $time, msg);
	endtask

	task automatic write_word(input rsa_host_pkg::target_e target, input int index,
		input rsa_arith_pkg::word_t data);
		wr_valid = 1'b1;
		wr.target = target;
		wr.index = 6'(index);
		wr.data = data;
		step();
		wr_valid = 1'b0;
	endtask

	task automatic load_operand(input rsa_host_pkg::target_e target,
		input logic [OP_W-1:0] value);
		for (int k = 0; k < WORDS; k++)
			write_word(target, k, value[k*WW +: WW]);
	endtask

	task automatic pulse_start();
		start = 1'b1;
		step();
		start = 1'b0;
	endtask

	task automatic run_row(input int r);
		logic [OP_W-1:0] got;
		int nvalid;
		int ndone;
		got = '0;
		nvalid = 0;
		ndone = 0;
		if (!rows[r].reload) begin
			load_operand(rsa_host_pkg::TGT_EXP, rows[r].exp_val);
			load_operand(rsa_host_pkg::TGT_MOD, rows[r].modulus);
		end
		load_operand(rsa_host_pkg::TGT_MSG, rows[r].message);
		pulse_start();
		if (!busy)
			report($sformatf("row %0d busy low after start", r));
		// a second start and message noise, both while busy
		pulse_start();
		for (int k = 0; k < WORDS; k++)
			write_word(rsa_host_pkg::TGT_MSG, k, $random(seed));
		while (busy) begin
			if (result_valid) begin
				if (nvalid < WORDS)
					got[(WORDS-1-nvalid)*WW +: WW] = result;
				if (done) begin
					ndone++;
					if (nvalid != WORDS - 1)
						report($sformatf("row %0d done on word %0d", r, nvalid));
				end
				nvalid++;
			end
			step();
		end
		if (got !== rows[r].expected)
			report($sformatf("row %0d got %h expected %h", r, got, rows[r].expected));
		if (nvalid != WORDS)
			report($sformatf("row %0d gave %0d result words", r, nvalid));
		if (ndone != 1)
			report($sformatf("row %0d gave %0d done pulses", r, ndone));
	endtask

	initial begin
		rst_n = 1'b0;
		wr_valid = 1'b0;
		wr = '0;
		start = 1'b0;
		errors = 0;
		seed = 32'h92a07365;
		// exponent, modulus, message, reload only, expected
		rows[0] = '{64'h0, 64'hE7B3_91C4_5D2A_6F0B, 64'h0123_4567_89AB_CDEF, 1'b0, '0};
		rows[1] = '{64'h1, 64'hE7B3_91C4_5D2A_6F0B, 64'hFEDC_BA98_7654_3210, 1'b0, '0};
		rows[2] = '{64'hD3F1_0A57_29C6_B8E5, 64'hC5A1_3E27_9B4D_F0E3,
			64'h5A5A_1234_0F0F_9876, 1'b0, '0};
		rows[3] = '{64'hD3F1_0A57_29C6_B8E5, 64'hC5A1_3E27_9B4D_F0E3,
			64'h0000_0000_DEAD_BEEF, 1'b1, '0};
		rows[4] = '{64'h1_0001, 64'hF123_4567, 64'h1_2345_6789, 1'b0, '0};
		for (int r = 0; r < NUM_ROWS; r++)
			rows[r].expected = mod_pow(rows[r].message, rows[r].exp_val, rows[r].modulus);
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		if (busy || result_valid || done)
			report("outputs not idle after reset");
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);
		$display("rows run %0d, errors %0d", NUM_ROWS, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire
